// File: filelist.f
+incdir+.
game_pkg.sv
shape_lookup.sv
pixel_colorize.sv
win_screen_top.sv
win_screen_assertions.sv
tb_win_screen.sv

// File: game_pkg.sv
/*
 * Shared definitions for the end-of-game overlay
 * Screen size, colour constants, VGA timing bundle,
 * pixel class enum and rectangle descriptor
 */

package game_pkg;

    // Visible area
    localparam int h_pixels = 1024;
    localparam int v_pixels = 768;

    localparam int coord_w = 11;
    localparam int color_w = 12;

    typedef logic [coord_w-1:0] coord_t;

    // 4 bits per channel with red in the top nibble
    typedef logic [color_w-1:0] rgb_t;

    // One pixel's worth of timing, 26 bits
    typedef struct packed {
        coord_t vcount;
        logic   vsync;
        logic   vblnk;
        coord_t hcount;
        logic   hsync;
        logic   hblnk;
    } vga_timing_t;

    // What a pixel belongs to, before it gets a colour
    typedef enum logic [1:0] {
        px_background = 2'd0,
        px_winner     = 2'd1,
        px_frame      = 2'd2
    } pixel_class_t;

    // Open rectangle with both bounds exclusive on each axis
    typedef struct packed {
        coord_t       v_lo;
        coord_t       v_hi;
        coord_t       h_lo;
        coord_t       h_hi;
        pixel_class_t cls;
    } rect_t;

    localparam rgb_t black_color = 12'h0_0_0;

    // Outline of the play again box
    localparam rgb_t frame_color = 12'h0_0_f;

    // Orange
    localparam rgb_t default_winner_color = 12'hf_8_0;

endpackage

// File: pixel_colorize.sv
/*
 * Stage two of the overlay pipeline
 * Turns the pixel class into a 12-bit colour, blacks out
 * blanking, and registers colour with timing
 */

module pixel_colorize #(
    parameter game_pkg::rgb_t winner_color = game_pkg::default_winner_color
) (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::vga_timing_t  stage_timing,
    input  game_pkg::pixel_class_t stage_class,
    output game_pkg::vga_timing_t  vga_out,
    output game_pkg::rgb_t         rgb
);

    game_pkg::rgb_t rgb_nxt;

    always_comb begin
        if (stage_timing.vblnk || stage_timing.hblnk) begin
            rgb_nxt = game_pkg::black_color;
        end else begin
            case (stage_class)
                game_pkg::px_winner: rgb_nxt = winner_color;
                game_pkg::px_frame:  rgb_nxt = game_pkg::frame_color;
                default:             rgb_nxt = game_pkg::black_color;
            endcase
        end
    end

    // Timing moves along with the colour it belongs to
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
            rgb     <= '0;
        end else begin
            vga_out <= stage_timing;
            rgb     <= rgb_nxt;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the win screen testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_win_screen -Mdir obj_dir -f filelist.f

# The simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/Vtb_win_screen > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: shape_lookup.sv
/*
 * Stage one of the overlay pipeline
 * Classifies each pixel as border, glyph, box outline or
 * background, and registers the class with its timing
 */

module shape_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::vga_timing_t  vga_in,
    output game_pkg::vga_timing_t  stage_timing,
    output game_pkg::pixel_class_t stage_class
);

    `include "win_screen_shapes.svh"

    localparam game_pkg::coord_t h_last = game_pkg::coord_t'(game_pkg::h_pixels - 1);
    localparam game_pkg::coord_t v_last = game_pkg::coord_t'(game_pkg::v_pixels - 1);

    game_pkg::pixel_class_t class_nxt;
    logic                   on_border;

    function automatic logic in_rect(
        input game_pkg::rect_t  r,
        input game_pkg::coord_t h,
        input game_pkg::coord_t v
    );
        return (v > r.v_lo) && (v < r.v_hi) && (h > r.h_lo) && (h < r.h_hi);
    endfunction

    // Outermost ring of the visible frame
    assign on_border = (vga_in.hcount == '0) || (vga_in.vcount == '0) ||
                       (vga_in.hcount == h_last) || (vga_in.vcount == v_last);

    always_comb begin
        class_nxt = game_pkg::px_background;
        if (on_border) begin
            class_nxt = game_pkg::px_winner;
        end else begin
            // Walk backwards so the lowest matching index is the last write
            for (int i = n_shapes - 1; i >= 0; i--) begin
                if (in_rect(shape_table[i], vga_in.hcount, vga_in.vcount)) begin
                    class_nxt = shape_table[i].cls;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_timing <= '0;
            stage_class  <= game_pkg::px_background;
        end else begin
            stage_timing <= vga_in;
            stage_class  <= class_nxt;
        end
    end

endmodule

// File: tb_win_screen.sv
/*
 * Testbench for the win screen overlay
 * Clock and reset, a table of pixels with expected colours,
 * output checks against the input delayed by the pipeline
 */

module tb_win_screen;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 10;
    localparam int release_timeout = 20;
    localparam time run_limit = 1ms;

    // Edges from driving a pixel to seeing it on vga_out
    localparam int check_lag = 2;

    localparam game_pkg::rgb_t win = game_pkg::default_winner_color;
    localparam game_pkg::rgb_t blue = game_pkg::frame_color;
    localparam game_pkg::rgb_t black = 12'h000;

    typedef struct packed {
        game_pkg::coord_t hcount;
        game_pkg::coord_t vcount;
        logic             vblnk;
        logic             hblnk;
        game_pkg::rgb_t   exp_rgb;
    } stim_t;

    localparam int n_entries = 24;

    // hcount, vcount, vblnk, hblnk, expected colour
    localparam stim_t stim_table [n_entries] = '{
        // Border ring
        '{11'd0,    11'd300, 1'b0, 1'b0, win},
        '{11'd1023, 11'd300, 1'b0, 1'b0, win},
        '{11'd500,  11'd0,   1'b0, 1'b0, win},
        '{11'd500,  11'd767, 1'b0, 1'b0, win},
        '{11'd1023, 11'd0,   1'b0, 1'b0, win},
        // Letters
        '{11'd480,  11'd370, 1'b0, 1'b0, win},
        '{11'd420,  11'd350, 1'b0, 1'b0, win},
        '{11'd510,  11'd350, 1'b0, 1'b0, win},
        '{11'd580,  11'd335, 1'b0, 1'b0, win},
        // Box outline
        '{11'd500,  11'd432, 1'b0, 1'b0, blue},
        '{11'd240,  11'd480, 1'b0, 1'b0, blue},
        '{11'd785,  11'd480, 1'b0, 1'b0, blue},
        '{11'd500,  11'd527, 1'b0, 1'b0, blue},
        // Blanking wins over any shape
        '{11'd480,  11'd370, 1'b1, 1'b0, black},
        '{11'd480,  11'd370, 1'b0, 1'b1, black},
        '{11'd0,    11'd300, 1'b0, 1'b1, black},
        '{11'd500,  11'd767, 1'b1, 1'b0, black},
        '{11'd500,  11'd432, 1'b1, 1'b1, black},
        // Exclusive bounds and empty space
        '{11'd477,  11'd370, 1'b0, 1'b0, black},
        '{11'd100,  11'd100, 1'b0, 1'b0, black},
        '{11'd310,  11'd200, 1'b0, 1'b0, black},
        '{11'd237,  11'd430, 1'b0, 1'b0, black},
        '{11'd500,  11'd480, 1'b0, 1'b0, black},
        '{11'd1100, 11'd800, 1'b1, 1'b1, black}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    game_pkg::vga_timing_t vga_in;
    game_pkg::vga_timing_t vga_out;
    game_pkg::rgb_t        rgb;

    game_pkg::vga_timing_t sent [n_entries];
    integer                seed;

    always #50 clk = ~clk;

    win_screen_top #(
        .winner_color (game_pkg::default_winner_color)
    ) u_win_screen_top (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_in),
        .vga_out (vga_out),
        .rgb     (rgb)
    );

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs(input game_pkg::vga_timing_t exp_t,
                                 input game_pkg::rgb_t exp_rgb);
        compare("rgb", 32'(rgb), 32'(exp_rgb));
        compare("vga_out.hcount", 32'(vga_out.hcount), 32'(exp_t.hcount));
        compare("vga_out.vcount", 32'(vga_out.vcount), 32'(exp_t.vcount));
        compare("vga_out.hsync", 32'(vga_out.hsync), 32'(exp_t.hsync));
        compare("vga_out.vsync", 32'(vga_out.vsync), 32'(exp_t.vsync));
        compare("vga_out.hblnk", 32'(vga_out.hblnk), 32'(exp_t.hblnk));
        compare("vga_out.vblnk", 32'(vga_out.vblnk), 32'(exp_t.vblnk));
    endtask

    // Table entry as a pixel with random syncs
    function automatic game_pkg::vga_timing_t make_pixel(input stim_t s, input integer r);
        game_pkg::vga_timing_t t;
        t.hcount = s.hcount;
        t.vcount = s.vcount;
        t.hblnk  = s.hblnk;
        t.vblnk  = s.vblnk;
        t.hsync  = r[0];
        t.vsync  = r[1];
        return t;
    endfunction

    initial begin
        game_pkg::vga_timing_t t;
        integer                r;
        int                    wait_cycles;

        seed   = 9;
        rst    = 1'b1;
        vga_in = '0;

        // Input keeps moving during reset, outputs must stay at zero
        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            r = $random(seed);
            if (c == reset_cycles - 1) begin
                rst <= 1'b0;
            end
            vga_in <= make_pixel(stim_table[0], r);
            @(negedge clk);
            check_outputs('0, '0);
        end

        wait_cycles = 0;
        while (rst !== 1'b0) begin
            if (wait_cycles == release_timeout) begin
                $display("Reset was not released in time");
                $display("Test FAILED");
                $fatal(1, "Reset release timed out");
            end
            @(negedge clk);
            wait_cycles++;
        end

        // Stage two still holds its reset value one edge after release
        @(posedge clk);
        r = $random(seed);
        vga_in <= make_pixel(stim_table[0], r);
        @(negedge clk);
        check_outputs('0, '0);

        for (int i = 0; i < n_entries + check_lag; i++) begin
            @(posedge clk);
            if (i < n_entries) begin
                r = $random(seed);
                t = make_pixel(stim_table[i], r);
                vga_in <= t;
                sent[i] = t;
            end
            @(negedge clk);
            if (i >= check_lag) begin
                check_outputs(sent[i - check_lag], stim_table[i - check_lag].exp_rgb);
            end
        end

        $display("Test OK");
        $finish;
    end

    initial begin
        #(run_limit);
        $display("Simulation ran past its time limit");
        $display("Test FAILED");
        $fatal(1, "Time limit reached");
    end

endmodule

// File: win_screen_assertions.sv
/*
 * Concurrent checks on the win screen top level
 * Two-cycle pass-through of timing, black during blanking,
 * zero outputs while in reset
 */

module win_screen_assertions (
    input logic                  clk,
    input logic                  rst,
    input game_pkg::vga_timing_t vga_in,
    input game_pkg::vga_timing_t vga_out,
    input game_pkg::rgb_t        rgb
);

    timeunit 1ns;
    timeprecision 1ps;

    // Both capturing edges must have been out of reset
    timing_passes_through: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst) && !$past(rst, 2)) |-> (vga_out == $past(vga_in, 2))
    ) else $error("vga_out does not match vga_in from two cycles earlier");

    blank_is_black: assert property (
        @(posedge clk) (vga_out.vblnk || vga_out.hblnk) |-> (rgb == '0)
    ) else $error("rgb is not black during blanking");

    reset_clears_outputs: assert property (
        @(posedge clk) rst |=> ((vga_out == '0) && (rgb == '0))
    ) else $error("outputs are not zero after a reset edge");

endmodule

bind win_screen_top win_screen_assertions u_win_screen_assertions (
    .clk     (clk),
    .rst     (rst),
    .vga_in  (vga_in),
    .vga_out (vga_out),
    .rgb     (rgb)
);

// File: win_screen_shapes.svh
/*
 * Rectangle table of the win screen
 * Letters of WINS in the winner colour, then the four bars
 * of the play again box outline
 */

`ifndef WIN_SCREEN_SHAPES_SVH
`define WIN_SCREEN_SHAPES_SVH

localparam int n_shapes = 21;

// Fields are v_lo, v_hi, h_lo, h_hi, class; earlier entries win
localparam game_pkg::rect_t shape_table [n_shapes] = '{
    // W
    '{11'd330, 11'd410, 11'd417, 11'd427, game_pkg::px_winner},
    '{11'd390, 11'd400, 11'd427, 11'd437, game_pkg::px_winner},
    '{11'd380, 11'd390, 11'd437, 11'd447, game_pkg::px_winner},
    '{11'd390, 11'd400, 11'd447, 11'd457, game_pkg::px_winner},
    '{11'd330, 11'd410, 11'd457, 11'd467, game_pkg::px_winner},
    // I
    '{11'd330, 11'd410, 11'd477, 11'd487, game_pkg::px_winner},
    // N
    '{11'd330, 11'd410, 11'd497, 11'd507, game_pkg::px_winner},
    '{11'd340, 11'd360, 11'd507, 11'd517, game_pkg::px_winner},
    '{11'd360, 11'd380, 11'd517, 11'd527, game_pkg::px_winner},
    '{11'd380, 11'd400, 11'd527, 11'd537, game_pkg::px_winner},
    '{11'd330, 11'd410, 11'd537, 11'd547, game_pkg::px_winner},
    // S
    '{11'd330, 11'd340, 11'd567, 11'd597, game_pkg::px_winner},
    '{11'd340, 11'd360, 11'd557, 11'd567, game_pkg::px_winner},
    '{11'd360, 11'd370, 11'd567, 11'd597, game_pkg::px_winner},
    '{11'd370, 11'd400, 11'd597, 11'd607, game_pkg::px_winner},
    '{11'd400, 11'd410, 11'd567, 11'd597, game_pkg::px_winner},
    '{11'd390, 11'd400, 11'd557, 11'd567, game_pkg::px_winner},
    // Box outline in 5 px bars
    '{11'd430, 11'd435, 11'd237, 11'd787, game_pkg::px_frame},
    '{11'd430, 11'd530, 11'd237, 11'd242, game_pkg::px_frame},
    '{11'd430, 11'd530, 11'd782, 11'd787, game_pkg::px_frame},
    '{11'd525, 11'd530, 11'd237, 11'd787, game_pkg::px_frame}
};

`endif

// File: win_screen_top.sv
/*
 * Win screen overlay, top level
 * Two-stage pipeline, classify then colour, 2 cycles
 * from vga_in to vga_out and rgb
 */

module win_screen_top #(
    parameter game_pkg::rgb_t winner_color = game_pkg::default_winner_color
) (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_timing_t vga_in,
    output game_pkg::vga_timing_t vga_out,
    output game_pkg::rgb_t        rgb
);

    // Between the stages
    game_pkg::vga_timing_t  stage_timing;
    game_pkg::pixel_class_t stage_class;

    shape_lookup u_shape_lookup (
        .clk          (clk),
        .rst          (rst),
        .vga_in       (vga_in),
        .stage_timing (stage_timing),
        .stage_class  (stage_class)
    );

    pixel_colorize #(
        .winner_color (winner_color)
    ) u_pixel_colorize (
        .clk          (clk),
        .rst          (rst),
        .stage_timing (stage_timing),
        .stage_class  (stage_class),
        .vga_out      (vga_out),
        .rgb          (rgb)
    );

endmodule
